//--- Makefile
# Verilator build and run for the CAN receiver testbench

VERILATOR ?= verilator
TOP       ?= tbCanDecoder
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
hdl/canFramePkg.sv
hdl/canDecoderPkg.sv
hdl/canRxControl.sv
hdl/canFieldCapture.sv
hdl/canCrc15.sv
hdl/canDecoder.sv
sim/tbClockGen.sv
sim/canDecoder_chk.sv
sim/tbCanDecoder.sv

//--- hdl/canCrc15.sv
//--------------------------------------------------
// Bit-serial CAN CRC-15 and remainder check
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module canCrc15
(
  input  wire  Clock_SP,
  input  wire  i_reset,
  input  wire  i_bit,
  input  wire  i_frameStart,                           // Preload to zero
  input  wire  i_crcShift,                             // Feed i_bit this cycle
  output logic o_crcBad
);

  logic [canFramePkg::CRC_W-1:0] crcReg;
  logic [canFramePkg::CRC_W-1:0] crcBase;              // Register or fresh zero
  logic [canFramePkg::CRC_W-1:0] crcStep;
  logic                          feedback;

  // One LFSR step on a cleared register at SOF
  always_comb
  begin
    crcBase  = i_frameStart ? '0 : crcReg;
    feedback = i_bit ^ crcBase[canFramePkg::CRC_W-1];
    crcStep  = {crcBase[canFramePkg::CRC_W-2:0], 1'b0};
    if (feedback)
      crcStep = crcStep ^ canFramePkg::CRC_POLY;
  end

  always_ff @(posedge Clock_SP)
  begin
    if (i_reset)
      crcReg <= '0;
    else if (i_crcShift)
      crcReg <= crcStep;
  end

  // Received CRC included so a good frame leaves zero
  assign o_crcBad = |crcReg;

endmodule

`default_nettype wire

//--- hdl/canDecoder.sv
//--------------------------------------------------
// CAN 2.0 frame receiver top: control, capture, CRC
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module canDecoder
(
  input  wire                                Clock_SP,
  input  wire                                i_reset,
  input  wire                                i_bit,         // Sampled bus bit
  input  wire                                i_stuffSkip,   // From destuffer
  input  wire                                i_stuffError,  // From destuffer
  output logic                               o_frameValid,
  output logic                               o_frameError,
  output canDecoderPkg::errKind_e            o_errorKind,
  output logic                               o_extended,
  output logic                               o_remote,
  output logic [canFramePkg::DLC_W-1:0]      o_dlc,
  output logic [canFramePkg::ID_W-1:0]       o_id,
  output logic [canFramePkg::DATA_W-1:0]     o_data
);

  logic                              frameStart;
  canDecoderPkg::capField_e          capField;
  logic                              crcShift;
  logic                              crcBad;
  logic [canFramePkg::DLC_W-1:0]     dataBytes;

  // Frame sequencing and result pulses
  canRxControl u_control (
    .Clock_SP     (Clock_SP),
    .i_reset      (i_reset),
    .i_bit        (i_bit),
    .i_stuffSkip  (i_stuffSkip),
    .i_stuffError (i_stuffError),
    .i_crcBad     (crcBad),
    .i_extended   (o_extended),
    .i_dataBytes  (dataBytes),
    .o_frameStart (frameStart),
    .o_capField   (capField),
    .o_crcShift   (crcShift),
    .o_frameValid (o_frameValid),
    .o_frameError (o_frameError),
    .o_errorKind  (o_errorKind)
  );

  // Field registers
  canFieldCapture u_capture (
    .Clock_SP     (Clock_SP),
    .i_reset      (i_reset),
    .i_bit        (i_bit),
    .i_frameStart (frameStart),
    .i_capField   (capField),
    .o_id         (o_id),
    .o_extended   (o_extended),
    .o_remote     (o_remote),
    .o_dlc        (o_dlc),
    .o_dataBytes  (dataBytes),
    .o_data       (o_data)
  );

  // SOF through CRC field
  canCrc15 u_crc (
    .Clock_SP     (Clock_SP),
    .i_reset      (i_reset),
    .i_bit        (i_bit),
    .i_frameStart (frameStart),
    .i_crcShift   (crcShift),
    .o_crcBad     (crcBad)
  );

endmodule

`default_nettype wire

//--- hdl/canDecoderPkg.sv
//--------------------------------------------------
// Receiver state, capture select and error kinds
//--------------------------------------------------
`default_nettype none

package canDecoderPkg;

  // Receiver FSM, one state per frame field
  typedef enum logic [3:0] {
    ST_IDLE,                                           // Bus idle, waits for SOF
    ST_BASE_ID,                                        // 11 ID bits
    ST_SRR_RTR,                                        // RTR or SRR
    ST_IDE,                                            // Format select
    ST_EXT_ID,                                         // 18 extension bits
    ST_EXT_RTR,                                        // Extended RTR
    ST_RESERVED,                                       // r0, or r1 r0
    ST_DLC,                                            // Length code
    ST_DATA,                                           // Data bytes
    ST_CRC,                                            // CRC sequence
    ST_CRC_DELIM,
    ST_ACK,
    ST_ACK_DELIM,
    ST_EOF,                                            // 7 recessive bits
    ST_INTERMISSION,                                   // 3 recessive bits
    ST_RECOVER                                         // Wait out error frame
  } rxState_e;

  // Which capture register takes the bit
  typedef enum logic [2:0] {
    CAP_NONE, CAP_ID, CAP_RTR, CAP_IDE, CAP_DLC, CAP_DATA
  } capField_e;

  // Reported error
  typedef enum logic [1:0] {
    ERR_NONE, ERR_STUFF, ERR_CRC, ERR_FORM
  } errKind_e;

endpackage

`default_nettype wire

//--- hdl/canFieldCapture.sv
//--------------------------------------------------
// Capture registers for ID, RTR, IDE, DLC and data
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module canFieldCapture
(
  input  wire                                Clock_SP,
  input  wire                                i_reset,
  input  wire                                i_bit,
  input  wire                                i_frameStart,  // Clear at SOF
  input  wire canDecoderPkg::capField_e      i_capField,
  output logic [canFramePkg::ID_W-1:0]       o_id,
  output logic                               o_extended,
  output logic                               o_remote,
  output logic [canFramePkg::DLC_W-1:0]      o_dlc,
  output logic [canFramePkg::DLC_W-1:0]      o_dataBytes,   // Bytes to read
  output logic [canFramePkg::DATA_W-1:0]     o_data
);

  logic [canFramePkg::ID_W-1:0]   idReg;
  logic                           rtrReg;
  logic                           ideReg;
  logic [canFramePkg::DLC_W-1:0]  dlcRaw;               // Code as received
  logic [canFramePkg::DATA_W-1:0] dataReg;

  //--------------------------------------------------
  // Shift in the selected field
  //--------------------------------------------------
  always_ff @(posedge Clock_SP)
  begin
    if (i_reset || i_frameStart)
    begin
      idReg   <= '0;
      rtrReg  <= 1'b0;
      ideReg  <= 1'b0;
      dlcRaw  <= '0;
      dataReg <= '0;
    end
    else
    begin
      case (i_capField)
        canDecoderPkg::CAP_ID:
          idReg <= {idReg[canFramePkg::ID_W-2:0], i_bit};        // Base ends above extension
        canDecoderPkg::CAP_RTR:
          rtrReg <= i_bit;                                       // Extended RTR overwrites SRR
        canDecoderPkg::CAP_IDE:
          ideReg <= i_bit;
        canDecoderPkg::CAP_DLC:
          dlcRaw <= {dlcRaw[canFramePkg::DLC_W-2:0], i_bit};     // MSB first
        canDecoderPkg::CAP_DATA:
          dataReg <= {dataReg[canFramePkg::DATA_W-2:0], i_bit};  // First byte most significant
        default:
        begin
        end
      endcase
    end
  end

  // Codes 9 to 15 mean 8 bytes
  assign o_dlc = (dlcRaw > canFramePkg::MAX_BYTES) ? canFramePkg::MAX_BYTES : dlcRaw;

  // Remote frame carries no data
  assign o_dataBytes = rtrReg ? '0 : o_dlc;

  assign o_id       = idReg;
  assign o_extended = ideReg;
  assign o_remote   = rtrReg;
  assign o_data     = dataReg;

endmodule

`default_nettype wire

//--- hdl/canFramePkg.sv
//--------------------------------------------------
// CAN frame format constants: field widths, field
// lengths, CRC polynomial and bus-idle bit counts
//--------------------------------------------------
`default_nettype none

package canFramePkg;

  //--------------------------------------------------
  // Identifier
  //--------------------------------------------------
  localparam int ID_W        = 29;                     // Full extended ID
  localparam int BASE_ID_LEN = 11;                     // Standard ID part
  localparam int EXT_ID_LEN  = 18;                     // Extension part

  //--------------------------------------------------
  // Control and data field
  //--------------------------------------------------
  localparam int DLC_W = 4;                            // Length code bits
  localparam logic [DLC_W-1:0] MAX_BYTES = 4'd8;       // Larger codes read as 8
  localparam int DATA_W = 64;                          // 8 bytes max

  //--------------------------------------------------
  // CRC and trailer
  //--------------------------------------------------
  localparam int CRC_W = 15;                           // CRC sequence length
  localparam logic [CRC_W-1:0] CRC_POLY = 15'h4599;    // x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
  localparam int EOF_LEN = 7;                          // Recessive EOF bits

  // Bus idle handling
  localparam int INTERMISSION_LEN = 3;                 // Before next SOF
  localparam int RECOVERY_LEN     = 8;                 // Recessive run after error

  // Field bit counter, widest field is 64 data bits
  localparam int CNT_W = 7;

endpackage

`default_nettype wire

//--- hdl/canRxControl.sv
//--------------------------------------------------
// CAN receive FSM: field sequencing, bit counter,
// form checks and result pulses
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module canRxControl
(
  input  wire                                Clock_SP,
  input  wire                                i_reset,
  input  wire                                i_bit,        // Sampled bus bit, 1 recessive
  input  wire                                i_stuffSkip,  // Stuff bit, not counted
  input  wire                                i_stuffError,
  input  wire                                i_crcBad,
  input  wire                                i_extended,   // Captured IDE
  input  wire [canFramePkg::DLC_W-1:0]       i_dataBytes,
  output logic                               o_frameStart,
  output canDecoderPkg::capField_e           o_capField,
  output logic                               o_crcShift,
  output logic                               o_frameValid,
  output logic                               o_frameError,
  output canDecoderPkg::errKind_e            o_errorKind
);

  canDecoderPkg::rxState_e        state, stateNext;
  logic [canFramePkg::CNT_W-1:0]  cnt, cntNext;        // Bit index inside field
  logic                           validNext;
  logic                           errNext;
  canDecoderPkg::errKind_e        kindNext;
  logic                           inStuff;              // SOF+1 to last CRC bit

  // True on the last bit of a field of len bits
  function automatic logic atLast(input logic [canFramePkg::CNT_W-1:0] count,
                                  input int len);
    atLast = (int'(count) == len - 1);
  endfunction

  assign inStuff = (state inside {[canDecoderPkg::ST_BASE_ID : canDecoderPkg::ST_CRC]});

  assign o_frameStart = (state == canDecoderPkg::ST_IDLE) && !i_bit;  // Dominant SOF
  assign o_crcShift   = o_frameStart
                      || (inStuff && !i_stuffSkip && !i_stuffError);

  //--------------------------------------------------
  // Next state, capture select and result
  //--------------------------------------------------
  always_comb
  begin
    stateNext  = state;
    cntNext    = cnt;
    validNext  = 1'b0;
    errNext    = 1'b0;
    kindNext   = o_errorKind;                           // Held until next error
    o_capField = canDecoderPkg::CAP_NONE;

    if (inStuff && i_stuffError)
    begin
      stateNext = canDecoderPkg::ST_RECOVER;            // Abort frame
      cntNext   = '0;
      errNext   = 1'b1;
      kindNext  = canDecoderPkg::ERR_STUFF;
    end
    else if (!inStuff || !i_stuffSkip)                  // Stuff bits leave all untouched
    begin
      cntNext = cnt + 1'b1;
      case (state)
        canDecoderPkg::ST_IDLE:
        begin
          cntNext = '0;
          if (!i_bit)
            stateNext = canDecoderPkg::ST_BASE_ID;
        end
        canDecoderPkg::ST_BASE_ID:
        begin
          o_capField = canDecoderPkg::CAP_ID;
          if (atLast(cnt, canFramePkg::BASE_ID_LEN))
          begin
            stateNext = canDecoderPkg::ST_SRR_RTR;
            cntNext   = '0;
          end
        end
        canDecoderPkg::ST_SRR_RTR:
        begin
          o_capField = canDecoderPkg::CAP_RTR;          // SRR if extended and replaced later
          stateNext  = canDecoderPkg::ST_IDE;
        end
        canDecoderPkg::ST_IDE:
        begin
          o_capField = canDecoderPkg::CAP_IDE;
          cntNext    = '0;
          stateNext  = i_bit ? canDecoderPkg::ST_EXT_ID : canDecoderPkg::ST_RESERVED;
        end
        canDecoderPkg::ST_EXT_ID:
        begin
          o_capField = canDecoderPkg::CAP_ID;
          if (atLast(cnt, canFramePkg::EXT_ID_LEN))
          begin
            stateNext = canDecoderPkg::ST_EXT_RTR;
            cntNext   = '0;
          end
        end
        canDecoderPkg::ST_EXT_RTR:
        begin
          o_capField = canDecoderPkg::CAP_RTR;
          stateNext  = canDecoderPkg::ST_RESERVED;
          cntNext    = '0;                              // r1 r0 counted from zero
        end
        canDecoderPkg::ST_RESERVED:                     // r0 only or r1 r0
        begin
          if (!i_extended || atLast(cnt, 2))
          begin
            stateNext = canDecoderPkg::ST_DLC;
            cntNext   = '0;
          end
        end
        canDecoderPkg::ST_DLC:
        begin
          o_capField = canDecoderPkg::CAP_DLC;
          if (atLast(cnt, canFramePkg::DLC_W))
          begin
            stateNext = canDecoderPkg::ST_DATA;         // Byte count known next cycle
            cntNext   = '0;
          end
        end
        canDecoderPkg::ST_DATA:
        begin
          if (i_dataBytes == '0)
          begin
            stateNext = canDecoderPkg::ST_CRC;          // No data so this is CRC bit 0
            cntNext   = 1;
          end
          else
          begin
            o_capField = canDecoderPkg::CAP_DATA;
            if (atLast(cnt, int'(i_dataBytes) * 8))
            begin
              stateNext = canDecoderPkg::ST_CRC;
              cntNext   = '0;
            end
          end
        end
        canDecoderPkg::ST_CRC:
        begin
          if (atLast(cnt, canFramePkg::CRC_W))
            stateNext = canDecoderPkg::ST_CRC_DELIM;
        end
        canDecoderPkg::ST_CRC_DELIM:
        begin
          cntNext   = '0;
          stateNext = canDecoderPkg::ST_ACK;
          if (!i_bit || i_crcBad)                       // Form wins over CRC
          begin
            stateNext = canDecoderPkg::ST_RECOVER;
            errNext   = 1'b1;
            kindNext  = !i_bit ? canDecoderPkg::ERR_FORM : canDecoderPkg::ERR_CRC;
          end
        end
        canDecoderPkg::ST_ACK:
          stateNext = canDecoderPkg::ST_ACK_DELIM;      // Any level accepted
        canDecoderPkg::ST_ACK_DELIM, canDecoderPkg::ST_EOF:
        begin
          if (state == canDecoderPkg::ST_ACK_DELIM)
          begin
            stateNext = canDecoderPkg::ST_EOF;
            cntNext   = '0;
          end
          else if (atLast(cnt, canFramePkg::EOF_LEN))
          begin
            stateNext = canDecoderPkg::ST_INTERMISSION;
            cntNext   = '0;
            validNext = i_bit;
          end
          if (!i_bit)                                   // Delimiter or EOF must be recessive
          begin
            stateNext = canDecoderPkg::ST_RECOVER;
            cntNext   = '0;
            errNext   = 1'b1;
            kindNext  = canDecoderPkg::ERR_FORM;
          end
        end
        default:                                        // Intermission and recovery
        begin
          if (!i_bit)
            cntNext = '0;                               // Dominant restarts the run
          else if ((state == canDecoderPkg::ST_INTERMISSION
                    && atLast(cnt, canFramePkg::INTERMISSION_LEN))
                   || atLast(cnt, canFramePkg::RECOVERY_LEN))
          begin
            stateNext = canDecoderPkg::ST_IDLE;
            cntNext   = '0;
          end
        end
      endcase
    end
  end

  //--------------------------------------------------
  // State and result registers
  //--------------------------------------------------
  always_ff @(posedge Clock_SP)
  begin
    if (i_reset)
    begin
      state        <= canDecoderPkg::ST_IDLE;           // Counts as past intermission
      cnt          <= '0;
      o_frameValid <= 1'b0;
      o_frameError <= 1'b0;
      o_errorKind  <= canDecoderPkg::ERR_NONE;
    end
    else
    begin
      state        <= stateNext;
      cnt          <= cntNext;
      o_frameValid <= validNext;                        // One-cycle pulses
      o_frameError <= errNext;
      o_errorKind  <= kindNext;
    end
  end

endmodule

`default_nettype wire

//--- sim/canDecoder_chk.sv
//--------------------------------------------------
// Concurrent assertions on the receiver result pulses
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module canDecoderChk
(
  input wire                      Clock_SP,
  input wire                      i_reset,
  input wire                      i_frameValid,
  input wire                      i_frameError,
  input wire canDecoderPkg::errKind_e i_errorKind
);

  // Good frame and error never reported together
  assert property (@(posedge Clock_SP) disable iff (i_reset)
    !(i_frameValid && i_frameError))
    else $error("frame valid and frame error high in the same cycle");

  // Single-cycle pulses
  assert property (@(posedge Clock_SP) disable iff (i_reset)
    i_frameValid |=> !i_frameValid)
    else $error("frame valid longer than one cycle");

  assert property (@(posedge Clock_SP) disable iff (i_reset)
    i_frameError |=> !i_frameError)
    else $error("frame error longer than one cycle");

  // An error always carries its kind
  assert property (@(posedge Clock_SP) disable iff (i_reset)
    i_frameError |-> (i_errorKind != canDecoderPkg::ERR_NONE))
    else $error("frame error with no error kind");

endmodule

bind canDecoder canDecoderChk u_chk (
  .Clock_SP     (Clock_SP),
  .i_reset      (i_reset),
  .i_frameValid (o_frameValid),
  .i_frameError (o_frameError),
  .i_errorKind  (o_errorKind)
);

`default_nettype wire

//--- sim/tbCanDecoder.sv
//--------------------------------------------------
// CAN receiver testbench: frame builder, reference
// CRC, stimulus, result checker and summary
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbCanDecoder;

  localparam int NUM_FRAMES     = 40;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 200 + 100;
  localparam int IDLE_BITS      = 10;                  // Covers intermission and recovery

  logic                                Clock_SP;
  logic                                reset;
  logic                                busBit;
  logic                                stuffSkip;
  logic                                stuffError;
  logic                                frameValid;
  logic                                frameError;
  canDecoderPkg::errKind_e             errorKind;
  logic                                extended;
  logic                                remote;
  logic [canFramePkg::DLC_W-1:0]       dlc;
  logic [canFramePkg::ID_W-1:0]        id;
  logic [canFramePkg::DATA_W-1:0]      data;

  // Frame under construction
  logic                                frameBits[$];
  logic                                fieldStart[$];  // First bit of a field
  int                                  crcLastIdx;
  int                                  crcDelimIdx;
  int                                  ackDelimIdx;
  int                                  eofIdx;
  logic [canFramePkg::ID_W-1:0]        curId;
  logic                                curExt;
  logic                                curRtr;
  logic [canFramePkg::DLC_W-1:0]       curDlc;
  logic [canFramePkg::DATA_W-1:0]      curData;

  // Pending expectations, one entry per frame
  canDecoderPkg::errKind_e             expKindQ[$];
  logic [canFramePkg::ID_W-1:0]        expIdQ[$];
  logic                                expExtQ[$];
  logic                                expRemQ[$];
  logic [canFramePkg::DLC_W-1:0]       expDlcQ[$];
  logic [canFramePkg::DATA_W-1:0]      expDataQ[$];
  canDecoderPkg::errKind_e             popKind;
  logic [canFramePkg::ID_W-1:0]        popId;
  logic                                popExt;
  logic                                popRem;
  logic [canFramePkg::DLC_W-1:0]       popDlc;
  logic [canFramePkg::DATA_W-1:0]      popData;

  int                                  errorCount = 0;
  int                                  checkCount = 0;
  int                                  cycleCount = 0;
  logic [31:0]                         lfsrState = 32'h7f110989;

  tbClockGen u_clkGen (
    .o_clock (Clock_SP),
    .o_reset (reset)
  );

  canDecoder u_dut (
    .Clock_SP     (Clock_SP),
    .i_reset      (reset),
    .i_bit        (busBit),
    .i_stuffSkip  (stuffSkip),
    .i_stuffError (stuffError),
    .o_frameValid (frameValid),
    .o_frameError (frameError),
    .o_errorKind  (errorKind),
    .o_extended   (extended),
    .o_remote     (remote),
    .o_dlc        (dlc),
    .o_id         (id),
    .o_data       (data)
  );

  //--------------------------------------------------
  // Random bits and reference CRC
  //--------------------------------------------------
  function automatic logic nextRandBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];  // Taps 32 22 2 1
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] randomBits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[62:0], nextRandBit()};                    // One step per bit
    return r;
  endfunction

  // CAN CRC-15 over SOF through the last data bit
  function automatic logic [14:0] refCrc15(input logic bits[$]);
    logic [14:0] crc;
    logic        fb;
    crc = '0;
    foreach (bits[i])
    begin
      fb  = bits[i] ^ crc[14];
      crc = {crc[13:0], 1'b0};
      if (fb)
        crc = crc ^ 15'h4599;                          // x^15+x^14+x^10+x^8+x^7+x^4+x^3+1
    end
    return crc;
  endfunction

  //--------------------------------------------------
  // Frame builder
  //--------------------------------------------------
  task automatic appendBits(input logic [63:0] value, input int width);
    for (int i = width - 1; i >= 0; i--)
    begin
      frameBits.push_back(value[i]);                   // MSB first on the bus
      fieldStart.push_back(i == width - 1);
    end
  endtask

  task automatic buildFrame(input logic ext, input logic rtr, input logic [28:0] frameId,
                            input logic [3:0] code, input logic [63:0] payload);
    int          nBytes;
    logic [14:0] crc;
    frameBits.delete();
    fieldStart.delete();
    frameBits.push_back(1'b0);                         // SOF
    fieldStart.push_back(1'b0);
    appendBits(64'(ext ? frameId[28:18] : frameId[10:0]), 11);
    if (ext)
    begin
      appendBits(64'd1, 1);                            // SRR
      appendBits(64'd1, 1);                            // IDE
      appendBits(64'(frameId[17:0]), 18);
      appendBits(64'(rtr), 1);
      appendBits(64'd0, 2);                            // r1 r0
    end
    else
    begin
      appendBits(64'(rtr), 1);
      appendBits(64'd0, 1);                            // IDE
      appendBits(64'd0, 1);                            // r0
    end
    appendBits(64'(code), 4);
    curDlc  = (code > 4'd8) ? 4'd8 : code;
    nBytes  = rtr ? 0 : int'(curDlc);
    curData = '0;
    for (int k = 0; k < nBytes; k++)
    begin
      appendBits(64'(payload[63 - 8 * k -: 8]), 8);
      curData = {curData[55:0], payload[63 - 8 * k -: 8]};  // First byte ends on top
    end
    crc = refCrc15(frameBits);
    appendBits(64'(crc), 15);
    crcLastIdx  = frameBits.size() - 1;
    crcDelimIdx = frameBits.size();
    appendBits(64'b101, 3);                            // Delimiter, ACK, ACK delimiter
    ackDelimIdx = crcDelimIdx + 2;
    eofIdx      = frameBits.size();
    appendBits(64'h7f, 7);
    curExt = ext;
    curRtr = rtr;
    curId  = ext ? frameId : {18'd0, frameId[10:0]};
  endtask

  task automatic buildRandom(input logic ext, input logic rtr, input logic [3:0] code);
    buildFrame(ext, rtr, 29'(randomBits(29)), code, randomBits(64));
  endtask

  task automatic expectGood();
    expKindQ.push_back(canDecoderPkg::ERR_NONE);
    expIdQ.push_back(curId);
    expExtQ.push_back(curExt);
    expRemQ.push_back(curRtr);
    expDlcQ.push_back(curDlc);
    expDataQ.push_back(curData);
  endtask

  task automatic expectError(input canDecoderPkg::errKind_e kind);
    expKindQ.push_back(kind);
    expIdQ.push_back('0);
    expExtQ.push_back(1'b0);
    expRemQ.push_back(1'b0);
    expDlcQ.push_back('0);
    expDataQ.push_back('0);
  endtask

  //--------------------------------------------------
  // Bus driver
  //--------------------------------------------------
  task automatic driveBit(input logic b, input logic skip, input logic serr);
    @(posedge Clock_SP);
    busBit     <= b;
    stuffSkip  <= skip;
    stuffError <= serr;
  endtask

  // Stops after abortAt, then idles recessive
  task automatic sendFrame(input logic useSkips, input int abortAt, input int stuffErrAt);
    for (int i = 0; i < frameBits.size(); i++)
    begin
      if (useSkips && fieldStart[i] && i <= crcLastIdx)
        driveBit(nextRandBit(), 1'b1, 1'b0);           // Stuff bit between fields
      driveBit(frameBits[i], 1'b0, i == stuffErrAt);
      if (i == abortAt)
        break;
    end
    repeat (IDLE_BITS) driveBit(1'b1, 1'b0, 1'b0);
  endtask

  //--------------------------------------------------
  // Compare tasks
  //--------------------------------------------------
  task automatic checkFlag(input string name, input logic exp, input logic act);
    checkCount++;
    if (act !== exp)
    begin
      errorCount++;
      $display("** Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
    end
  endtask

  task automatic checkId(input string name, input logic [canFramePkg::ID_W-1:0] exp,
                         input logic [canFramePkg::ID_W-1:0] act);
    checkCount++;
    if (act !== exp)
    begin
      errorCount++;
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic checkData(input string name, input logic [canFramePkg::DATA_W-1:0] exp,
                           input logic [canFramePkg::DATA_W-1:0] act);
    checkCount++;
    if (act !== exp)
    begin
      errorCount++;
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic checkDlc(input string name, input logic [canFramePkg::DLC_W-1:0] exp,
                          input logic [canFramePkg::DLC_W-1:0] act);
    checkCount++;
    if (act !== exp)
    begin
      errorCount++;
      $display("** Error at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic checkErrKind(input string name, input canDecoderPkg::errKind_e exp,
                              input canDecoderPkg::errKind_e act);
    checkCount++;
    if (act !== exp)
    begin
      errorCount++;
      $display("** Error at %0t ns: %s expected %s, actual %s", $time, name,
               exp.name(), act.name());
    end
  endtask

  //--------------------------------------------------
  // Result checker, samples mid-cycle
  //--------------------------------------------------
  always @(negedge Clock_SP)
  begin
    if (!reset && (frameValid || frameError))
    begin
      if (expKindQ.size() == 0)
      begin
        errorCount++;
        $display("Unexpected result pulse at %0t ns with no frame pending", $time);
      end
      else
      begin
        popKind = expKindQ.pop_front();
        popId   = expIdQ.pop_front();
        popExt  = expExtQ.pop_front();
        popRem  = expRemQ.pop_front();
        popDlc  = expDlcQ.pop_front();
        popData = expDataQ.pop_front();
        if (popKind == canDecoderPkg::ERR_NONE)
        begin
          checkFlag("o_frameValid", 1'b1, frameValid);
          checkId("o_id", popId, id);
          checkFlag("o_extended", popExt, extended);
          checkFlag("o_remote", popRem, remote);
          checkDlc("o_dlc", popDlc, dlc);
          checkData("o_data", popData, data);
        end
        else
        begin
          checkFlag("o_frameError", 1'b1, frameError);
          checkFlag("o_frameValid", 1'b0, frameValid);
          checkErrKind("o_errorKind", popKind, errorKind);
        end
      end
    end
  end

  // Run limit
  always @(posedge Clock_SP)
  begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //--------------------------------------------------
  // Stimulus
  //--------------------------------------------------
  initial
  begin
    busBit     = 1'b1;
    stuffSkip  = 1'b0;
    stuffError = 1'b0;
    wait (reset == 1'b0);
    repeat (4) driveBit(1'b1, 1'b0, 1'b0);

    for (int d = 0; d <= 8; d++)                       // Standard data, DLC 0 to 8
    begin
      buildRandom(1'b0, 1'b0, 4'(d));
      expectGood();
      sendFrame(1'b0, -1, -1);
    end
    repeat (6)                                         // Extended data
    begin
      buildRandom(1'b1, 1'b0, 4'(randomBits(4)));
      expectGood();
      sendFrame(1'b0, -1, -1);
    end
    for (int r = 0; r < 4; r++)                        // Remote, std and ext
    begin
      buildRandom(r[0], 1'b1, 4'(randomBits(4)));
      expectGood();
      sendFrame(1'b0, -1, -1);
    end
    buildRandom(1'b0, 1'b0, 4'd9);                     // Clamped DLC
    expectGood();
    sendFrame(1'b0, -1, -1);
    buildRandom(1'b0, 1'b0, 4'd12);
    expectGood();
    sendFrame(1'b0, -1, -1);
    buildRandom(1'b1, 1'b0, 4'd15);
    expectGood();
    sendFrame(1'b0, -1, -1);

    // Flipped CRC bit, then recovery
    buildRandom(1'b0, 1'b0, 4'd3);
    frameBits[crcLastIdx - 3] = !frameBits[crcLastIdx - 3];
    expectError(canDecoderPkg::ERR_CRC);
    sendFrame(1'b0, crcDelimIdx, -1);
    buildRandom(1'b0, 1'b0, 4'd5);
    expectGood();
    sendFrame(1'b0, -1, -1);

    // Form and stuff errors
    buildRandom(1'b1, 1'b0, 4'd2);
    frameBits[ackDelimIdx] = 1'b0;
    expectError(canDecoderPkg::ERR_FORM);
    sendFrame(1'b0, ackDelimIdx, -1);
    buildRandom(1'b0, 1'b0, 4'd4);
    frameBits[eofIdx + 3] = 1'b0;
    expectError(canDecoderPkg::ERR_FORM);
    sendFrame(1'b0, eofIdx + 3, -1);
    buildRandom(1'b0, 1'b0, 4'd1);
    expectError(canDecoderPkg::ERR_STUFF);
    sendFrame(1'b0, 5, 5);                             // Inside base ID
    buildRandom(1'b1, 1'b0, 4'd8);
    expectGood();
    sendFrame(1'b0, -1, -1);

    // Same frame with and without stuff bits
    for (int s = 0; s < 6; s++)
    begin
      buildRandom(s[0], s == 4, 4'(randomBits(4)));
      expectGood();
      sendFrame(1'b1, -1, -1);
      expectGood();
      sendFrame(1'b0, -1, -1);
    end

    repeat (50)
    begin
      if (expKindQ.size() == 0)
        break;
      @(posedge Clock_SP);
    end
    if (expKindQ.size() != 0)
    begin
      errorCount++;
      $display("Missing result pulse for %0d frames", expKindQ.size());
    end

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tbClockGen.sv
//--------------------------------------------------
// Testbench clock and reset generator
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbClockGen
(
  output logic o_clock,
  output logic o_reset
);

  localparam int HALF_PERIOD = 20;                     // 40 ns sample-point clock
  localparam int RESET_CYCLES = 4;

  initial
  begin
    o_clock = 1'b0;
    forever #HALF_PERIOD o_clock = ~o_clock;
  end

  initial
  begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clock);
    o_reset <= 1'b0;                                   // Release on an edge
  end

endmodule

`default_nettype wire
